// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= geom_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
hw/geom_pkg.sv
hw/scene_mem.sv
hw/mem_arbiter.sv
hw/triangle_fetch.sv
hw/world_camera_transformer.sv
hw/geom_top.sv
tests/geom_tb.sv

// ==== hw/geom_pkg.sv ====
package geom_pkg;

    // Signed Q8.8 coordinate
    typedef logic signed [15:0] coord_t;
    typedef logic [23:0] color_t;

    // x, y, z, color from the top bits down; also the scene memory word
    typedef logic [71:0] vertex_t;

    // v0 in the top bits
    typedef logic [215:0] triangle_t;

    // Camera position x, y, z
    typedef logic [47:0] pos_t;

    // R11 .. R33 in row order, R11 on top
    typedef logic [143:0] mtx_t;

    // Vertex slot within a triangle
    typedef logic [1:0] vidx_t;

    function automatic coord_t vtx_x(vertex_t v);
        return v[71:56];
    endfunction

    function automatic coord_t vtx_y(vertex_t v);
        return v[55:40];
    endfunction

    function automatic coord_t vtx_z(vertex_t v);
        return v[39:24];
    endfunction

    function automatic color_t vtx_color(vertex_t v);
        return v[23:0];
    endfunction

    function automatic vertex_t make_vertex(coord_t x, coord_t y, coord_t z, color_t c);
        return {x, y, z, c};
    endfunction

    function automatic vertex_t tri_vertex(triangle_t t, vidx_t i);
        case (i)
            2'd0: return t[215:144];
            2'd1: return t[143:72];
            default: return t[71:0];
        endcase
    endfunction

    function automatic triangle_t set_tri_vertex(triangle_t t, vidx_t i, vertex_t v);
        triangle_t r;
        r = t;
        case (i)
            2'd0: r[215:144] = v;
            2'd1: r[143:72] = v;
            default: r[71:0] = v;
        endcase
        return r;
    endfunction

    // Axis 0..2 selects x, y, z
    function automatic coord_t pos_axis(pos_t p, int i);
        return p[47 - 16 * i -: 16];
    endfunction

    // Row and column count from 1, as in R11
    function automatic coord_t mtx_elem(mtx_t m, int row, int col);
        return m[143 - 16 * ((row - 1) * 3 + (col - 1)) -: 16];
    endfunction

    // Q8.8 dot product, each term truncated before the sum
    function automatic coord_t dot3(coord_t a0, coord_t a1, coord_t a2,
                                   coord_t b0, coord_t b1, coord_t b2);
        logic signed [31:0] p0;
        logic signed [31:0] p1;
        logic signed [31:0] p2;
        logic signed [31:0] sum;
        p0 = a0 * b0;
        p1 = a1 * b1;
        p2 = a2 * b2;
        p0 = p0 >>> 8;
        p1 = p1 >>> 8;
        p2 = p2 >>> 8;
        sum = p0 + p1 + p2;
        return sum[15:0];
    endfunction

endpackage

// ==== hw/geom_top.sv ====
`timescale 1ns/1ps

module geom_top #(
    parameter int ADDR_W = 8
) (
    input  logic                clk,
    input  logic                rst,

    // Host memory load, only while idle
    input  logic                mem_we,
    input  logic [ADDR_W-1:0]   mem_waddr,
    input  geom_pkg::vertex_t   mem_wdata,

    input  geom_pkg::pos_t      cam_pos,
    input  geom_pkg::mtx_t      cam_rot,
    input  logic [ADDR_W-1:0]   tri_count,
    input  logic                start,

    // Lane 0, even triangles
    output geom_pkg::triangle_t out_triangle_0,
    output logic                out_valid_0,
    input  logic                out_ready_0,

    // Lane 1, odd triangles
    output geom_pkg::triangle_t out_triangle_1,
    output logic                out_valid_1,
    input  logic                out_ready_1,

    output logic                busy
);

    logic                mem_re;
    logic [ADDR_W-1:0]   mem_raddr;
    geom_pkg::vertex_t   mem_rdata;

    logic                rd_req_0;
    logic                rd_req_1;
    logic [ADDR_W-1:0]   rd_addr_0;
    logic [ADDR_W-1:0]   rd_addr_1;
    logic                rd_gnt_0;
    logic                rd_gnt_1;
    logic                rd_valid_0;
    logic                rd_valid_1;
    geom_pkg::vertex_t   rd_data_0;
    geom_pkg::vertex_t   rd_data_1;

    geom_pkg::triangle_t fetch_tri_0;
    geom_pkg::triangle_t fetch_tri_1;
    logic                fetch_valid_0;
    logic                fetch_valid_1;
    logic                fetch_ready_0;
    logic                fetch_ready_1;
    logic                active_0;
    logic                active_1;
    logic                xf_busy_0;
    logic                xf_busy_1;

    scene_mem #(.ADDR_W(ADDR_W)) scene_mem_i (
        .clk(clk), .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
        .re(mem_re), .raddr(mem_raddr), .rdata(mem_rdata)
    );

    mem_arbiter #(.ADDR_W(ADDR_W)) mem_arbiter_i (
        .clk(clk), .rst(rst),
        .req_0(rd_req_0), .req_1(rd_req_1), .addr_0(rd_addr_0), .addr_1(rd_addr_1),
        .gnt_0(rd_gnt_0), .gnt_1(rd_gnt_1),
        .rvalid_0(rd_valid_0), .rvalid_1(rd_valid_1),
        .rdata_0(rd_data_0), .rdata_1(rd_data_1),
        .mem_re(mem_re), .mem_raddr(mem_raddr), .mem_rdata(mem_rdata)
    );

    triangle_fetch #(.ADDR_W(ADDR_W), .LANE(0), .STRIDE(2)) fetch_0_i (
        .clk(clk), .rst(rst), .start(start), .tri_count(tri_count),
        .rd_req(rd_req_0), .rd_addr(rd_addr_0), .rd_gnt(rd_gnt_0),
        .rd_valid(rd_valid_0), .rd_data(rd_data_0),
        .tri_out(fetch_tri_0), .tri_valid(fetch_valid_0), .tri_ready(fetch_ready_0),
        .active(active_0)
    );

    triangle_fetch #(.ADDR_W(ADDR_W), .LANE(1), .STRIDE(2)) fetch_1_i (
        .clk(clk), .rst(rst), .start(start), .tri_count(tri_count),
        .rd_req(rd_req_1), .rd_addr(rd_addr_1), .rd_gnt(rd_gnt_1),
        .rd_valid(rd_valid_1), .rd_data(rd_data_1),
        .tri_out(fetch_tri_1), .tri_valid(fetch_valid_1), .tri_ready(fetch_ready_1),
        .active(active_1)
    );

    world_camera_transformer xform_0_i (
        .clk(clk), .rst(rst), .cam_pos(cam_pos), .cam_rot(cam_rot),
        .in_triangle(fetch_tri_0), .in_valid(fetch_valid_0), .in_ready(fetch_ready_0),
        .out_triangle(out_triangle_0), .out_valid(out_valid_0), .out_ready(out_ready_0),
        .busy(xf_busy_0)
    );

    world_camera_transformer xform_1_i (
        .clk(clk), .rst(rst), .cam_pos(cam_pos), .cam_rot(cam_rot),
        .in_triangle(fetch_tri_1), .in_valid(fetch_valid_1), .in_ready(fetch_ready_1),
        .out_triangle(out_triangle_1), .out_valid(out_valid_1), .out_ready(out_ready_1),
        .busy(xf_busy_1)
    );

    // Fetch activity hands over to transformer busy on the same edge
    assign busy = active_0 | active_1 | xf_busy_0 | xf_busy_1;

endmodule

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int ADDR_W = 8
) (
    input  logic                clk,
    input  logic                rst,

    // Lane request side
    input  logic                req_0,
    input  logic                req_1,
    input  logic [ADDR_W-1:0]   addr_0,
    input  logic [ADDR_W-1:0]   addr_1,
    output logic                gnt_0,
    output logic                gnt_1,

    // Lane return side
    output logic                rvalid_0,
    output logic                rvalid_1,
    output geom_pkg::vertex_t   rdata_0,
    output geom_pkg::vertex_t   rdata_1,

    // Memory read port
    output logic                mem_re,
    output logic [ADDR_W-1:0]   mem_raddr,
    input  geom_pkg::vertex_t   mem_rdata
);

    // Lane served by the most recent grant
    logic last_served;

    // A read is in flight, and which lane it belongs to
    logic pend;
    logic owner;

    // On a tie, the lane not served last wins
    assign gnt_0 = req_0 && (!req_1 || last_served);
    assign gnt_1 = req_1 && (!req_0 || !last_served);

    assign mem_re    = gnt_0 | gnt_1;
    assign mem_raddr = gnt_1 ? addr_1 : addr_0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Lane 0 goes first after reset
            last_served <= 1'b1;
            pend        <= 1'b0;
            owner       <= 1'b0;
        end else begin
            pend <= mem_re;
            if (mem_re) begin
                owner       <= gnt_1;
                last_served <= gnt_1;
            end
        end
    end

    // Data fans out; only the owner sees a valid strobe
    assign rvalid_0 = pend && !owner;
    assign rvalid_1 = pend && owner;
    assign rdata_0  = mem_rdata;
    assign rdata_1  = mem_rdata;

endmodule

// ==== hw/scene_mem.sv ====
`timescale 1ns/1ps

module scene_mem #(
    parameter int ADDR_W = 8
) (
    input  logic                clk,

    // Host load port
    input  logic                we,
    input  logic [ADDR_W-1:0]   waddr,
    input  geom_pkg::vertex_t   wdata,

    // Read port, owned by the arbiter
    input  logic                re,
    input  logic [ADDR_W-1:0]   raddr,
    output geom_pkg::vertex_t   rdata
);

    // One vertex per word, triangle i at 3i .. 3i+2
    geom_pkg::vertex_t mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, data valid the cycle after re
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== hw/triangle_fetch.sv ====
`timescale 1ns/1ps

module triangle_fetch #(
    parameter int ADDR_W = 8,
    parameter int LANE   = 0,
    parameter int STRIDE = 2
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                start,
    input  logic [ADDR_W-1:0]   tri_count,

    // Read port towards the arbiter
    output logic                rd_req,
    output logic [ADDR_W-1:0]   rd_addr,
    input  logic                rd_gnt,
    input  logic                rd_valid,
    input  geom_pkg::vertex_t   rd_data,

    // Triangle handed to the transformer
    output geom_pkg::triangle_t tri_out,
    output logic                tri_valid,
    input  logic                tri_ready,

    output logic                active
);

    typedef enum logic [1:0] {IDLE, READ, OFFER} state_t;
    state_t state;

    logic [ADDR_W-1:0]   idx;
    logic [ADDR_W:0]     next_idx;
    geom_pkg::vidx_t     req_cnt;
    geom_pkg::vidx_t     ret_cnt;
    geom_pkg::triangle_t tri_r;

    // One spare bit so the last step cannot wrap past tri_count
    assign next_idx = {1'b0, idx} + (ADDR_W + 1)'(STRIDE);

    // Base address 3*idx plus the vertex being requested
    assign rd_addr = ADDR_W'((idx << 1) + idx + ADDR_W'(req_cnt));
    assign rd_req  = (state == READ) && (req_cnt != 2'd3);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            idx     <= '0;
            req_cnt <= 2'd0;
            ret_cnt <= 2'd0;
        end else begin
            case (state)
                IDLE: begin
                    if (start && (ADDR_W'(LANE) < tri_count)) begin
                        idx     <= ADDR_W'(LANE);
                        req_cnt <= 2'd0;
                        ret_cnt <= 2'd0;
                        state   <= READ;
                    end
                end
                READ: begin
                    if (rd_gnt) begin
                        req_cnt <= req_cnt + 2'd1;
                    end
                    if (rd_valid) begin
                        ret_cnt <= ret_cnt + 2'd1;
                        if (ret_cnt == 2'd2) begin
                            state <= OFFER;
                        end
                    end
                end
                OFFER: begin
                    if (tri_ready) begin
                        req_cnt <= 2'd0;
                        ret_cnt <= 2'd0;
                        if (next_idx >= {1'b0, tri_count}) begin
                            state <= IDLE;
                        end else begin
                            idx   <= next_idx[ADDR_W-1:0];
                            state <= READ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Returned words land in the slot of the read that produced them
    always_ff @(posedge clk) begin
        if (state == READ && rd_valid) begin
            tri_r <= geom_pkg::set_tri_vertex(tri_r, ret_cnt, rd_data);
        end
    end

    assign tri_out   = tri_r;
    assign tri_valid = (state == OFFER);
    assign active    = (state != IDLE);

endmodule

// ==== hw/world_camera_transformer.sv ====
`timescale 1ns/1ps

module world_camera_transformer (
    input  logic                clk,
    input  logic                rst,

    // Camera levels, sampled on acceptance
    input  geom_pkg::pos_t      cam_pos,
    input  geom_pkg::mtx_t      cam_rot,

    input  geom_pkg::triangle_t in_triangle,
    input  logic                in_valid,
    output logic                in_ready,

    output geom_pkg::triangle_t out_triangle,
    output logic                out_valid,
    input  logic                out_ready,

    output logic                busy
);

    typedef enum logic [1:0] {IDLE, PROCESS, DONE} state_t;
    state_t state;

    // Triangle and camera held for the whole transaction
    geom_pkg::triangle_t tri_r;
    geom_pkg::pos_t      pos_r;
    geom_pkg::mtx_t      rot_r;

    // Next vertex to issue, 3 once all are in the pipeline
    geom_pkg::vidx_t vertex_idx;
    logic            issue_valid;
    logic            accept;
    logic            last_vertex_done;
    geom_pkg::vertex_t cur_v;

    // Translate stage
    logic             t_valid;
    geom_pkg::vidx_t  t_idx;
    geom_pkg::coord_t t_x;
    geom_pkg::coord_t t_y;
    geom_pkg::coord_t t_z;
    geom_pkg::color_t t_color;

    // Rotate stage
    logic              r_valid;
    geom_pkg::vidx_t   r_idx;
    geom_pkg::vertex_t r_vertex;

    // Collected camera-space triangle
    geom_pkg::triangle_t tri_acc;

    assign accept      = (state == IDLE) && in_valid;
    assign issue_valid = (state == PROCESS) && (vertex_idx != 2'd3);
    assign cur_v       = geom_pkg::tri_vertex(tri_r, vertex_idx);

    assign last_vertex_done = r_valid && (r_idx == 2'd2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            vertex_idx <= 2'd0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        vertex_idx <= 2'd0;
                        state      <= PROCESS;
                    end
                end
                PROCESS: begin
                    if (vertex_idx != 2'd3) begin
                        vertex_idx <= vertex_idx + 2'd1;
                    end
                    // Last vertex out of the rotate stage
                    if (last_vertex_done) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (out_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tri_r <= in_triangle;
            pos_r <= cam_pos;
            rot_r <= cam_rot;
        end
    end

    // Stage valids and indices
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            t_valid <= 1'b0;
            r_valid <= 1'b0;
            t_idx   <= 2'd0;
            r_idx   <= 2'd0;
        end else begin
            t_valid <= issue_valid;
            r_valid <= t_valid;
            t_idx   <= vertex_idx;
            r_idx   <= t_idx;
        end
    end

    // Stage 0: p - C
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            t_x     <= geom_pkg::vtx_x(cur_v) - geom_pkg::pos_axis(pos_r, 0);
            t_y     <= geom_pkg::vtx_y(cur_v) - geom_pkg::pos_axis(pos_r, 1);
            t_z     <= geom_pkg::vtx_z(cur_v) - geom_pkg::pos_axis(pos_r, 2);
            t_color <= geom_pkg::vtx_color(cur_v);
        end
    end

    // Stage 1: rows of R^T are the columns of R
    always_ff @(posedge clk) begin
        if (t_valid) begin
            r_vertex <= geom_pkg::make_vertex(
                geom_pkg::dot3(geom_pkg::mtx_elem(rot_r, 1, 1),
                               geom_pkg::mtx_elem(rot_r, 2, 1),
                               geom_pkg::mtx_elem(rot_r, 3, 1), t_x, t_y, t_z),
                geom_pkg::dot3(geom_pkg::mtx_elem(rot_r, 1, 2),
                               geom_pkg::mtx_elem(rot_r, 2, 2),
                               geom_pkg::mtx_elem(rot_r, 3, 2), t_x, t_y, t_z),
                geom_pkg::dot3(geom_pkg::mtx_elem(rot_r, 1, 3),
                               geom_pkg::mtx_elem(rot_r, 2, 3),
                               geom_pkg::mtx_elem(rot_r, 3, 3), t_x, t_y, t_z),
                t_color);
        end
    end

    // Results written by index, held through DONE
    always_ff @(posedge clk) begin
        if (r_valid) begin
            tri_acc <= geom_pkg::set_tri_vertex(tri_acc, r_idx, r_vertex);
        end
    end

    assign out_triangle = tri_acc;
    assign in_ready     = (state == IDLE);
    assign out_valid    = (state == DONE);
    assign busy         = (state != IDLE);

endmodule

// ==== tests/geom_cases.txt ====
# R count pos_x pos_y pos_z r11 r12 r13 r21 r22 r23 r31 r32 r33 (hex, Q8.8 except count)
# V world x y z color, then expected camera-space x y z color (hex)
R 3 0000 0000 0000 0100 0000 0000 0000 0100 0000 0000 0000 0100
V 0100 0200 0300 ff0000 0100 0200 0300 ff0000
V ff00 0080 fe40 00ff00 ff00 0080 fe40 00ff00
V 1234 8000 7fff 0000ff 1234 8000 7fff 0000ff
V 0000 0000 0000 123456 0000 0000 0000 123456
V fff1 0010 ff80 abcdef fff1 0010 ff80 abcdef
V 0a00 f600 0001 808080 0a00 f600 0001 808080
V 7f00 8100 00c0 010203 7f00 8100 00c0 010203
V ffff ffff ffff ffffff ffff ffff ffff ffffff
V 0040 0020 0010 000000 0040 0020 0010 000000
# Camera at (1.0, -1.5, 0.25), R maps to x' = -y, y' = x, z' = x/4 + z/2
R 2 0100 fe80 0040 0000 0100 0040 ff00 0000 0000 0000 0000 0080
V 0300 0100 0200 aa5500 fd80 0200 0160 aa5500
V ff00 fe00 ffc3 123456 0080 fe00 ff41 123456
V 0103 0005 0047 00ff00 fe7b 0003 0003 00ff00
V 7f80 7f00 8010 ffffff 7f80 7e80 5f88 ffffff
V 0000 0000 0000 000000 fe80 ff00 ffa0 000000
V 8000 fd00 0041 0a0b0c 0180 7f00 1fc0 0a0b0c

// ==== tests/geom_tb.sv ====
`timescale 1ns/1ps

module geom_tb;

    localparam int ADDR_W = 8;
    localparam logic [31:0] SEED = 32'ha46345b4;
    localparam int CYCLES_PER_TRI = 40;
    localparam int CYCLE_MARGIN = 100;

    logic clk;
    logic rst;
    logic mem_we;
    logic [ADDR_W-1:0] mem_waddr;
    geom_pkg::vertex_t mem_wdata;
    geom_pkg::pos_t cam_pos;
    geom_pkg::mtx_t cam_rot;
    logic [ADDR_W-1:0] tri_count;
    logic start;
    logic [1:0] out_valid;
    logic [1:0] out_ready;
    geom_pkg::triangle_t out_tri [2];
    logic busy;

    // Three world and three expected vertices per triangle of the current run
    geom_pkg::vertex_t world_q [$];
    geom_pkg::vertex_t expect_q [$];
    int run_count;
    int run_base [2];

    // Accepted outputs per lane over all runs, and the output seen held last cycle
    int accepted [2];
    logic [1:0] held;
    geom_pkg::triangle_t held_tri [2];

    int cycle;
    int deadline;

    geom_top #(.ADDR_W(ADDR_W)) geom_top_i (
        .clk(clk), .rst(rst),
        .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .cam_pos(cam_pos), .cam_rot(cam_rot), .tri_count(tri_count), .start(start),
        .out_triangle_0(out_tri[0]), .out_valid_0(out_valid[0]), .out_ready_0(out_ready[0]),
        .out_triangle_1(out_tri[1]), .out_valid_1(out_valid[1]), .out_ready_1(out_ready[1]),
        .busy(busy)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_equal(input logic [215:0] got, input logic [215:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Next line that is neither blank nor a comment
    task automatic read_record(input int fd, output string line, output bit found);
        int code;
        found = 1'b0;
        while (!found && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 1 && line.getc(0) != "#") begin
                found = 1'b1;
            end
        end
    endtask

    task automatic run_scene(input int count, input geom_pkg::pos_t pos,
                             input geom_pkg::mtx_t rot);
        deadline = cycle + CYCLES_PER_TRI * count + CYCLE_MARGIN;
        run_count = count;
        run_base[0] = accepted[0];
        run_base[1] = accepted[1];
        // Host loads one vertex per cycle while the lanes are idle
        for (int i = 0; i < 3 * count; i++) begin
            @(posedge clk);
            mem_we    <= 1'b1;
            mem_waddr <= ADDR_W'(i);
            mem_wdata <= world_q[i];
        end
        @(posedge clk);
        mem_we    <= 1'b0;
        cam_pos   <= pos;
        cam_rot   <= rot;
        tri_count <= ADDR_W'(count);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        check_equal(216'(busy), 216'(1), "busy after start");
        while (busy) begin
            @(posedge clk);
        end
        // Every triangle taken exactly once by the time busy drops
        check_equal(216'(accepted[0] - run_base[0]), 216'((count + 1) / 2),
                    "lane 0 triangles accepted");
        check_equal(216'(accepted[1] - run_base[1]), 216'(count / 2),
                    "lane 1 triangles accepted");
        check_equal(216'(out_valid), '0, "out_valid after the run");
    endtask

    initial begin : backpressure
        out_ready = 2'b00;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            out_ready <= {($urandom % 4) != 0, ($urandom % 4) != 0};
        end
    end

    always @(posedge clk) begin : monitor
        int k;
        int idx;
        geom_pkg::triangle_t exp_tri;
        if (rst) begin
            held <= 2'b00;
        end else begin
            for (int lane = 0; lane < 2; lane++) begin
                if (held[lane]) begin
                    check_equal(216'(out_valid[lane]), 216'(1),
                                $sformatf("lane %0d out_valid while held", lane));
                    check_equal(out_tri[lane], held_tri[lane],
                                $sformatf("lane %0d output changed while held", lane));
                end
                if (out_valid[lane] && out_ready[lane]) begin
                    // Lane n owns triangles n, n+2, n+4 ...
                    k = accepted[lane] - run_base[lane];
                    idx = lane + 2 * k;
                    if (idx >= run_count) begin
                        $display("Lane %0d produced more triangles than the run holds", lane);
                        abort_run();
                    end
                    exp_tri = {expect_q[3 * idx], expect_q[3 * idx + 1], expect_q[3 * idx + 2]};
                    check_equal(out_tri[lane], exp_tri,
                                $sformatf("lane %0d triangle %0d", lane, idx));
                    accepted[lane] <= accepted[lane] + 1;
                end
                held[lane] <= out_valid[lane] && !out_ready[lane];
                held_tri[lane] <= out_tri[lane];
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle <= cycle + 1;
        if (cycle >= deadline) begin
            $display("Timeout: the run did not finish within its budget, cycle %0d", cycle);
            abort_run();
        end
    end

    initial begin : main
        int fd;
        int runs;
        int count;
        string line;
        bit found;
        logic [15:0] cam [12];
        logic [15:0] wx, wy, wz, ex, ey, ez;
        logic [23:0] wc, ec;
        clk = 1'b0;
        rst = 1'b1;
        mem_we = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        cam_pos = '0;
        cam_rot = '0;
        tri_count = '0;
        start = 1'b0;
        runs = 0;
        deadline = CYCLE_MARGIN;
        fd = $fopen("tests/geom_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file tests/geom_cases.txt");
            abort_run();
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        check_equal(216'(out_valid), '0, "out_valid after reset");
        check_equal(216'(busy), '0, "busy after reset");

        read_record(fd, line, found);
        while (found) begin
            if ($sscanf(line, "R %h %h %h %h %h %h %h %h %h %h %h %h %h", count,
                        cam[0], cam[1], cam[2], cam[3], cam[4], cam[5],
                        cam[6], cam[7], cam[8], cam[9], cam[10], cam[11]) != 13) begin
                $display("Malformed run line in the case file: %s", line);
                abort_run();
            end
            world_q.delete();
            expect_q.delete();
            for (int i = 0; i < 3 * count; i++) begin
                read_record(fd, line, found);
                if (!found || $sscanf(line, "V %h %h %h %h %h %h %h %h",
                                      wx, wy, wz, wc, ex, ey, ez, ec) != 8) begin
                    $display("Missing or malformed vertex line %0d of run %0d", i, runs);
                    abort_run();
                end
                world_q.push_back({wx, wy, wz, wc});
                expect_q.push_back({ex, ey, ez, ec});
            end
            run_scene(count, {cam[0], cam[1], cam[2]},
                      {cam[3], cam[4], cam[5], cam[6], cam[7], cam[8],
                       cam[9], cam[10], cam[11]});
            runs++;
            read_record(fd, line, found);
        end
        $fclose(fd);
        if (runs < 2) begin
            $display("The case file held only %0d runs, two are needed", runs);
            abort_run();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule
